// ==== list.f ====
verilog/countrate_pkg.sv
verilog/tag_fifo.sv
verilog/window_tracker.sv
verilog/tag_classifier.sv
verilog/channel_counters.sv
verilog/countrate.sv
tests/countrate_checker.sv
tests/countrate_tb.sv

// ==== run.sh ====
#!/bin/sh
# builds the count-rate meter testbench with Verilator, runs it and checks the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f list.f --top-module countrate_tb -o countrate_sim
./obj_dir/countrate_sim | tee sim.log

if grep -q "RESULT: FAIL" sim.log; then
    exit 1
fi
exit 0

// ==== tests/countrate_checker.sv ====
// reference window model for the count-rate meter, follows the driven tags and checks every count strobe
`timescale 1ns/1ps
`default_nettype none

module countrate_checker #(
    parameter int COUNTER_WIDTH = 32,
    parameter int MAX_WINDOWS   = 2048
) (
    input  logic                                clk,
    input  logic                                rst,
    input  countrate_pkg::tag_word_t            tags_i,
    input  logic [countrate_pkg::TAG_WIDTH-1:0] window_size_i,
    input  logic                                start_counting_i,
    input  logic [COUNTER_WIDTH-1:0]            count_data_i [countrate_pkg::NUM_CHANNELS],
    input  logic                                count_valid_i,
    output int                                  value_errors_o,
    output int                                  other_errors_o,
    output int                                  strobe_count_o,
    output int                                  closed_count_o
);
    import countrate_pkg::*;

    localparam int WIN_BITS = $clog2(MAX_WINDOWS);
    localparam int CH_BITS  = $clog2(NUM_CHANNELS);

    // expected counts per window and channel, window 0 opens at the first word
    logic [COUNTER_WIDTH-1:0] model_counts [MAX_WINDOWS][NUM_CHANNELS];
    logic [COUNTER_WIDTH-1:0] last_data    [NUM_CHANNELS];
    logic [TAG_WIDTH-1:0]     first_time;
    logic [TAG_WIDTH-1:0]     win_size;
    logic                     started;
    logic                     opened;
    logic                     seen_strobe;
    logic [WIN_BITS:0]        closed_windows;
    logic [WIN_BITS:0]        checked_windows;
    int                       value_errors;
    int                       strobe_errors;
    int                       table_errors;
    int                       strobe_count;

    // inputs taken at the rising edge, the model runs ahead of the DUT pipeline
    always @(posedge clk) begin : follow_tags
        logic [TAG_WIDTH-1:0] quot;
        logic                 any_valid;
        logic [WIN_BITS-1:0]  widx;
        logic [CH_BITS-1:0]   ch;
        if (rst) begin
            started        = 1'b0;
            opened         = 1'b0;
            closed_windows = '0;
            table_errors   = 0;
            for (int w = 0; w < MAX_WINDOWS; w++) begin
                for (int c = 0; c < NUM_CHANNELS; c++) begin
                    model_counts[w][c] = '0;
                end
            end
        end else begin
            any_valid = 1'b0;
            for (int l = 0; l < NUM_TAGS; l++) begin
                any_valid = any_valid | tags_i[l].valid;
            end
            if (start_counting_i) begin
                started = 1'b1;
            end
            if (any_valid && started && !opened) begin
                // opens at the last valid lane, this word itself is not counted
                opened   = 1'b1;
                win_size = window_size_i;
                for (int l = 0; l < NUM_TAGS; l++) begin
                    if (tags_i[l].valid) begin
                        first_time = tags_i[l].tag_time;
                    end
                end
            end else if (any_valid && opened) begin
                for (int l = 0; l < NUM_TAGS; l++) begin
                    if (tags_i[l].valid) begin
                        // offset modulo 2^64, a tag on a window end goes to the later window
                        quot = (tags_i[l].tag_time - first_time) / win_size;
                        if (quot >= TAG_WIDTH'(MAX_WINDOWS)) begin
                            table_errors++;
                            $display("model window table too small for tag time %h",
                                     tags_i[l].tag_time);
                        end else begin
                            widx = quot[WIN_BITS-1:0];
                            // every window before this one is now closed
                            if ({1'b0, widx} > closed_windows) begin
                                closed_windows = {1'b0, widx};
                            end
                            // keep-alive channels only move the windows
                            if (tags_i[l].channel < CHANNEL_WIDTH'(NUM_CHANNELS)) begin
                                ch = tags_i[l].channel[CH_BITS-1:0];
                                model_counts[widx][ch] = model_counts[widx][ch] +
                                                         COUNTER_WIDTH'(1);
                            end
                        end
                    end
                end
            end
        end
    end

    // outputs read mid-cycle, settled since the rising edge
    always @(negedge clk) begin : check_counts
        logic [COUNTER_WIDTH-1:0] expected;
        logic                     changed;
        if (rst) begin
            checked_windows = '0;
            strobe_count    = 0;
            value_errors    = 0;
            strobe_errors   = 0;
            seen_strobe     = 1'b0;
        end else if (count_valid_i) begin
            strobe_count++;
            if (checked_windows >= closed_windows) begin
                strobe_errors++;
                $display("count strobe %0d came with no closed window in the model", strobe_count);
            end else begin
                for (int c = 0; c < NUM_CHANNELS; c++) begin
                    expected = model_counts[checked_windows[WIN_BITS-1:0]][c];
                    if (count_data_i[c] !== expected) begin
                        value_errors++;
                        $display("Error count_data_o[%0d] window %0d: expected %h, got %h",
                                 c, checked_windows, expected, count_data_i[c]);
                    end
                end
            end
            checked_windows = checked_windows + (WIN_BITS + 1)'(1);
            seen_strobe     = 1'b1;
            for (int c = 0; c < NUM_CHANNELS; c++) begin
                last_data[c] = count_data_i[c];
            end
        end else if (seen_strobe) begin
            // data must hold between strobes
            changed = 1'b0;
            for (int c = 0; c < NUM_CHANNELS; c++) begin
                if (count_data_i[c] !== last_data[c]) begin
                    changed = 1'b1;
                end
            end
            if (changed) begin
                strobe_errors++;
                $display("count_data_o changed while count_valid_o was low");
            end
        end
    end

    assign value_errors_o = value_errors;
    assign other_errors_o = strobe_errors + table_errors;
    assign strobe_count_o = strobe_count;
    assign closed_count_o = int'(closed_windows);

endmodule

`default_nettype wire

// ==== tests/countrate_tb.sv ====
// testbench for the count-rate meter, drives sorted random tag words and leaves the checks to the checker
`timescale 1ns/1ps
`default_nettype none

module countrate_tb;
    import countrate_pkg::*;

    localparam int FIFO_DEPTH    = 64;
    localparam int COUNTER_WIDTH = 32;
    localparam int NUM_WORDS     = 300;
    localparam int DRAIN_TIMEOUT = 4000;
    // close to 2^64 so the times wrap past zero during the run
    localparam logic [TAG_WIDTH-1:0] START_TIME = 64'hffff_ffff_fffe_0000;

    logic                     clk;
    logic                     rst;
    tag_word_t                tags;
    logic [TAG_WIDTH-1:0]     window_size;
    logic                     start_counting;
    logic [COUNTER_WIDTH-1:0] count_data [NUM_CHANNELS];
    logic                     count_valid;
    logic [31:0]              lfsr_state;
    logic [TAG_WIDTH-1:0]     tag_time;
    int                       value_errors;
    int                       other_errors;
    int                       strobe_count;
    int                       closed_count;
    int                       run_errors;
    int                       wait_cycles;

    always #2 clk = ~clk;

    countrate #(
        .FIFO_DEPTH    (FIFO_DEPTH),
        .COUNTER_WIDTH (COUNTER_WIDTH)
    ) countrate_inst (
        .clk              (clk),
        .rst              (rst),
        .tags_i           (tags),
        .window_size_i    (window_size),
        .start_counting_i (start_counting),
        .count_data_o     (count_data),
        .count_valid_o    (count_valid)
    );

    countrate_checker #(
        .COUNTER_WIDTH (COUNTER_WIDTH)
    ) countrate_checker_inst (
        .clk              (clk),
        .rst              (rst),
        .tags_i           (tags),
        .window_size_i    (window_size),
        .start_counting_i (start_counting),
        .count_data_i     (count_data),
        .count_valid_i    (count_valid),
        .value_errors_o   (value_errors),
        .other_errors_o   (other_errors),
        .strobe_count_o   (strobe_count),
        .closed_count_o   (closed_count)
    );

    // fibonacci step for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // n fresh bits, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    // one word of rising lane times, then two to five idle cycles
    task automatic drive_word();
        logic [31:0] chan;
        logic [31:0] pause;
        // now and then a gap of several whole windows
        if (rand_bits(4) == 32'd0) begin
            tag_time = tag_time + TAG_WIDTH'(rand_bits(3)) * window_size;
        end
        for (int l = 0; l < NUM_TAGS; l++) begin
            tag_time         = tag_time + 64'd1 + TAG_WIDTH'(rand_bits(8));
            // channels 16 to 19 are keep-alive
            chan             = rand_bits(5) % 32'd20;
            tags[l].valid    = (rand_bits(1) != 32'd0);
            tags[l].tag_time = tag_time;
            tags[l].channel  = CHANNEL_WIDTH'(chan);
        end
        @(negedge clk);
        tags  = '0;
        pause = rand_bits(2);
        repeat (2 + int'(pause)) @(negedge clk);
    endtask

    initial begin
        clk            = 1'b0;
        rst            = 1'b1;
        tags           = '0;
        start_counting = 1'b0;
        lfsr_state     = 32'h3cd1fac0;
        tag_time       = START_TIME;
        run_errors     = 0;
        window_size    = 64'd512 + TAG_WIDTH'(rand_bits(9));
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        // quiet line, then words that arrive before start and are dropped
        repeat (10) @(negedge clk);
        repeat (3) drive_word();
        repeat (12) @(negedge clk);
        start_counting = 1'b1;
        @(negedge clk);
        start_counting = 1'b0;
        repeat (4) @(negedge clk);
        for (int i = 0; i < NUM_WORDS; i++) begin
            drive_word();
        end
        // let the pipeline and any stall drain
        wait_cycles = 0;
        while (strobe_count != closed_count && wait_cycles < DRAIN_TIMEOUT) begin
            @(posedge clk);
            wait_cycles++;
        end
        if (strobe_count != closed_count) begin
            run_errors++;
            $display("timeout: %0d count strobes seen but %0d windows closed",
                     strobe_count, closed_count);
        end
        // no strobe may follow once the input is idle
        repeat (50) @(negedge clk);
        @(posedge clk);
        if (strobe_count != closed_count) begin
            run_errors++;
            $display("strobe total %0d does not match %0d closed windows",
                     strobe_count, closed_count);
        end
        $display("errors: value %0d, other %0d, run %0d; strobes %0d, windows %0d",
                 value_errors, other_errors, run_errors, strobe_count, closed_count);
        if (value_errors == 0 && other_errors == 0 && run_errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog/channel_counters.sv ====
// per-channel partial sums and window counters that latch the counts and pulse count_valid_o
`timescale 1ns/1ps
`default_nettype none

module channel_counters #(
    parameter int COUNTER_WIDTH = 32
) (
    input  logic                         clk,
    input  logic                         rst,
    input  countrate_pkg::channel_hits_t hits_i,
    input  logic                         update_window_i,
    input  logic                         meas_active_i,
    output logic [COUNTER_WIDTH-1:0]     count_data_o [countrate_pkg::NUM_CHANNELS],
    output logic                         count_valid_o
);
    import countrate_pkg::*;

    logic [SUM_WIDTH-1:0]     sum_cur_d [NUM_CHANNELS];
    logic [SUM_WIDTH-1:0]     sum_nxt_d [NUM_CHANNELS];
    logic [SUM_WIDTH-1:0]     sum_cur   [NUM_CHANNELS];
    logic [SUM_WIDTH-1:0]     sum_nxt   [NUM_CHANNELS];
    logic [COUNTER_WIDTH-1:0] counters  [NUM_CHANNELS];
    logic [2:0]               update_dly;

    // ones count of each lane mask
    always_comb begin
        for (int c = 0; c < NUM_CHANNELS; c++) begin
            sum_cur_d[c] = '0;
            sum_nxt_d[c] = '0;
            for (int l = 0; l < NUM_TAGS; l++) begin
                sum_cur_d[c] = sum_cur_d[c] + SUM_WIDTH'(hits_i.cur[c][l]);
                sum_nxt_d[c] = sum_nxt_d[c] + SUM_WIDTH'(hits_i.nxt[c][l]);
            end
        end
    end

    always_ff @(posedge clk) begin
        sum_cur <= sum_cur_d;
        sum_nxt <= sum_nxt_d;
    end

    // stage 1 lines up with the partial sums, stage 2 is the strobe
    always_ff @(posedge clk) begin
        if (rst) begin
            update_dly <= '0;
        end else begin
            update_dly <= {update_dly[1:0], update_window_i};
        end
    end

    // on a step the window total is the counter plus its last sum
    // the counter restarts from the tags already seen in the next window
    always_ff @(posedge clk) begin
        if (rst) begin
            counters <= '{default: '0};
        end else if (meas_active_i) begin
            for (int c = 0; c < NUM_CHANNELS; c++) begin
                if (update_dly[1]) begin
                    counters[c] <= COUNTER_WIDTH'(sum_nxt[c]);
                end else begin
                    counters[c] <= counters[c] + COUNTER_WIDTH'(sum_cur[c]);
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (update_dly[1]) begin
            for (int c = 0; c < NUM_CHANNELS; c++) begin
                count_data_o[c] <= counters[c] + COUNTER_WIDTH'(sum_cur[c]);
            end
        end
    end

    assign count_valid_o = update_dly[2];

endmodule

`default_nettype wire

// ==== verilog/countrate.sv ====
// top level of the count-rate meter that registers the tag input and links FIFO, tracker and counters
`timescale 1ns/1ps
`default_nettype none

module countrate #(
    parameter int FIFO_DEPTH    = 64,
    parameter int COUNTER_WIDTH = 32
) (
    input  logic                                clk,
    input  logic                                rst,
    input  countrate_pkg::tag_word_t            tags_i,
    input  logic [countrate_pkg::TAG_WIDTH-1:0] window_size_i,
    input  logic                                start_counting_i,
    output logic [COUNTER_WIDTH-1:0]            count_data_o [countrate_pkg::NUM_CHANNELS],
    output logic                                count_valid_o
);
    import countrate_pkg::*;

    tag_word_t            tags_q;
    logic [TAG_WIDTH-1:0] window_size_q;
    logic                 any_valid;
    logic                 any_valid_q;
    tag_word_t            head;
    logic                 head_valid;
    logic                 rd_en;
    tag_word_t            sel_word;
    lane_pos_word_t       lane_pos;
    logic                 update_window;
    logic                 meas_active;
    channel_hits_t        hits;

    // only words with at least one live lane get stored
    always_comb begin
        any_valid = 1'b0;
        for (int l = 0; l < NUM_TAGS; l++) begin
            any_valid = any_valid | tags_i[l].valid;
        end
    end

    always_ff @(posedge clk) begin
        tags_q        <= tags_i;
        window_size_q <= window_size_i;
        if (rst) begin
            any_valid_q <= 1'b0;
        end else begin
            any_valid_q <= any_valid;
        end
    end

    tag_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) tag_fifo_inst (
        .clk          (clk),
        .rst          (rst),
        .wr_en_i      (any_valid_q),
        .wr_word_i    (tags_q),
        .rd_en_i      (rd_en),
        .head_o       (head),
        .head_valid_o (head_valid)
    );

    window_tracker window_tracker_inst (
        .clk              (clk),
        .rst              (rst),
        .head_i           (head),
        .head_valid_i     (head_valid),
        .window_size_i    (window_size_q),
        .start_counting_i (start_counting_i),
        .rd_en_o          (rd_en),
        .sel_word_o       (sel_word),
        .lane_pos_o       (lane_pos),
        .update_window_o  (update_window),
        .meas_active_o    (meas_active)
    );

    tag_classifier tag_classifier_inst (
        .clk          (clk),
        .rst          (rst),
        .sel_word_i   (sel_word),
        .lane_pos_i   (lane_pos),
        .head_valid_i (head_valid),
        .hits_o       (hits)
    );

    channel_counters #(
        .COUNTER_WIDTH (COUNTER_WIDTH)
    ) channel_counters_inst (
        .clk             (clk),
        .rst             (rst),
        .hits_i          (hits),
        .update_window_i (update_window),
        .meas_active_i   (meas_active),
        .count_data_o    (count_data_o),
        .count_valid_o   (count_valid_o)
    );

endmodule

`default_nettype wire

// ==== verilog/countrate_pkg.sv ====
// shared widths and packed tag, window position and channel hit types used by every meter block
`default_nettype none

package countrate_pkg;

    // width of a tag time and of the window size
    localparam int TAG_WIDTH = 64;

    // tag lanes delivered per clock
    localparam int NUM_TAGS = 4;

    localparam int CHANNEL_WIDTH = 6;

    // lanes with a channel at or above this are keep-alive tags
    localparam int NUM_CHANNELS = 16;

    // per-channel partial sum, holds up to NUM_TAGS
    localparam int SUM_WIDTH = 3;

    // one lane as it comes from the front end
    typedef struct packed {
        logic                     valid;
        logic [TAG_WIDTH-1:0]     tag_time;
        logic [CHANNEL_WIDTH-1:0] channel;
    } tag_lane_t;

    // lane 0 in the low bits
    typedef tag_lane_t [NUM_TAGS-1:0] tag_word_t;

    // where one lane sits against the two window ends
    typedef struct packed {
        // valid, consumed this cycle and measurement running
        logic qualified;
        // time at or after window_end
        logic past_end;
        // time at or after next_window_end
        logic past_next;
    } lane_pos_t;

    typedef lane_pos_t [NUM_TAGS-1:0] lane_pos_word_t;

    // one bit per lane
    typedef logic [NUM_TAGS-1:0] lane_mask_t;

    // per-channel lane masks, current window and next window
    typedef struct packed {
        lane_mask_t [NUM_CHANNELS-1:0] cur;
        lane_mask_t [NUM_CHANNELS-1:0] nxt;
    } channel_hits_t;

endpackage

`default_nettype wire

// ==== verilog/tag_classifier.sv ====
// maps qualified lanes onto per-channel hit masks for the current and the next window, one cycle late
`timescale 1ns/1ps
`default_nettype none

module tag_classifier (
    input  logic                          clk,
    input  logic                          rst,
    input  countrate_pkg::tag_word_t      sel_word_i,
    input  countrate_pkg::lane_pos_word_t lane_pos_i,
    input  logic                          head_valid_i,
    output countrate_pkg::channel_hits_t  hits_o
);
    import countrate_pkg::*;

    logic [NUM_CHANNELS-1:0] ch_sel [NUM_TAGS];
    logic [NUM_TAGS-1:0]     to_cur;
    logic [NUM_TAGS-1:0]     to_next;
    channel_hits_t           hits_d;

    // one-hot channel per lane
    // keep-alive channels match no counted channel and vanish here
    always_comb begin
        for (int l = 0; l < NUM_TAGS; l++) begin
            for (int c = 0; c < NUM_CHANNELS; c++) begin
                ch_sel[l][c] = (sel_word_i[l].channel == CHANNEL_WIDTH'(c));
            end
        end
    end

    // current window only for lanes freshly read from the FIFO
    // a replayed word was already counted there
    always_comb begin
        for (int l = 0; l < NUM_TAGS; l++) begin
            to_cur[l]  = lane_pos_i[l].qualified && !lane_pos_i[l].past_end && head_valid_i;
            to_next[l] = lane_pos_i[l].qualified && lane_pos_i[l].past_end &&
                         !lane_pos_i[l].past_next;
        end
    end

    always_comb begin
        hits_d = '0;
        for (int c = 0; c < NUM_CHANNELS; c++) begin
            for (int l = 0; l < NUM_TAGS; l++) begin
                hits_d.cur[c][l] = to_cur[l] && ch_sel[l][c];
                hits_d.nxt[c][l] = to_next[l] && ch_sel[l][c];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            hits_o <= '0;
        end else begin
            hits_o <= hits_d;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/tag_fifo.sv ====
// synchronous first-word-fall-through FIFO that buffers tag words and shows the oldest one on head_o
`timescale 1ns/1ps
`default_nettype none

module tag_fifo #(
    parameter int FIFO_DEPTH = 64
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     wr_en_i,
    input  countrate_pkg::tag_word_t wr_word_i,
    input  logic                     rd_en_i,
    output countrate_pkg::tag_word_t head_o,
    output logic                     head_valid_o
);
    import countrate_pkg::*;

    localparam int PTR_WIDTH = $clog2(FIFO_DEPTH);
    localparam logic [PTR_WIDTH:0] FULL_COUNT = (PTR_WIDTH + 1)'(FIFO_DEPTH);

    tag_word_t            mem [FIFO_DEPTH];
    logic [PTR_WIDTH-1:0] wr_ptr;
    logic [PTR_WIDTH-1:0] rd_ptr;
    logic [PTR_WIDTH:0]   count;
    logic                 do_write;
    logic                 do_read;

    // a word arriving while full is lost
    assign do_write = wr_en_i && (count != FULL_COUNT);

    // head leaves in the same cycle it is flagged valid
    assign head_valid_o = (count != '0) && rd_en_i;
    assign do_read      = head_valid_o;

    // no read latency on the head
    assign head_o = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_write) begin
            mem[wr_ptr] <= wr_word_i;
        end
    end

    // pointers wrap naturally, depth is a power of two
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_write) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_read) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // simultaneous read and write leaves the count alone
            case ({do_write, do_read})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== verilog/window_tracker.sv ====
// window start and stepping logic that positions each lane and stalls the tag FIFO for far-future tags
`timescale 1ns/1ps
`default_nettype none

module window_tracker (
    input  logic                                clk,
    input  logic                                rst,
    input  countrate_pkg::tag_word_t            head_i,
    input  logic                                head_valid_i,
    input  logic [countrate_pkg::TAG_WIDTH-1:0] window_size_i,
    input  logic                                start_counting_i,
    output logic                                rd_en_o,
    output countrate_pkg::tag_word_t            sel_word_o,
    output countrate_pkg::lane_pos_word_t       lane_pos_o,
    output logic                                update_window_o,
    output logic                                meas_active_o
);
    import countrate_pkg::*;

    logic                 start_armed;
    logic                 meas_active;
    logic                 open_window;
    logic                 first_found;
    logic [TAG_WIDTH-1:0] first_time;
    logic [TAG_WIDTH-1:0] window_end;
    logic [TAG_WIDTH-1:0] next_window_end;
    logic [TAG_WIDTH-1:0] diff_end  [NUM_TAGS];
    logic [TAG_WIDTH-1:0] diff_next [NUM_TAGS];
    logic                 rd_en_q;
    logic                 rd_en_d;
    logic                 update_window;
    logic                 update_d1;
    tag_word_t            held_word;

    // with reads stopped the last consumed word is replayed
    assign sel_word_o = rd_en_q ? head_i : held_word;

    // highest valid lane of the head word, times rise with lane index
    always_comb begin
        first_found = 1'b0;
        first_time  = '0;
        for (int l = 0; l < NUM_TAGS; l++) begin
            if (head_i[l].valid) begin
                first_found = 1'b1;
                first_time  = head_i[l].tag_time;
            end
        end
    end

    assign open_window = !meas_active && start_armed && head_valid_i && first_found;

    // sign of the difference stays right after the time wraps past zero
    always_comb begin
        for (int l = 0; l < NUM_TAGS; l++) begin
            diff_end[l]  = sel_word_o[l].tag_time - window_end;
            diff_next[l] = sel_word_o[l].tag_time - next_window_end;
        end
    end

    // any live lane at or past window_end forces a step
    always_comb begin
        update_window = 1'b0;
        for (int l = 0; l < NUM_TAGS; l++) begin
            if (sel_word_o[l].valid && meas_active && (head_valid_i || !rd_en_q) &&
                !diff_end[l][TAG_WIDTH-1]) begin
                update_window = 1'b1;
            end
        end
    end

    // stop reading when a fresh lane lies beyond the next window
    always_comb begin
        rd_en_d = rd_en_q;
        for (int l = 0; l < NUM_TAGS; l++) begin
            if (sel_word_o[l].valid && meas_active && head_valid_i &&
                !diff_next[l][TAG_WIDTH-1]) begin
                rd_en_d = 1'b0;
            end
        end
        // steps have stopped, held lanes now sit in the current window
        if (!rd_en_q && update_d1 && !update_window) begin
            rd_en_d = 1'b1;
        end
    end

    // fresh lanes and held lanes still being walked towards are qualified
    always_comb begin
        for (int l = 0; l < NUM_TAGS; l++) begin
            lane_pos_o[l].qualified = sel_word_o[l].valid && meas_active &&
                                      (head_valid_i || !rd_en_d);
            lane_pos_o[l].past_end  = !diff_end[l][TAG_WIDTH-1];
            lane_pos_o[l].past_next = !diff_next[l][TAG_WIDTH-1];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            start_armed <= 1'b0;
            meas_active <= 1'b0;
            rd_en_q     <= 1'b1;
            update_d1   <= 1'b0;
        end else begin
            // armed until a word is consumed, one measurement per reset
            if (start_armed && head_valid_i) begin
                start_armed <= 1'b0;
            end else if (start_counting_i && !meas_active) begin
                start_armed <= 1'b1;
            end
            if (open_window) begin
                meas_active <= 1'b1;
            end
            rd_en_q   <= rd_en_d;
            update_d1 <= update_window;
        end
    end

    // window size is sampled at every step so a change lands two windows later
    always_ff @(posedge clk) begin
        if (head_valid_i) begin
            held_word <= head_i;
        end
        if (open_window) begin
            window_end      <= first_time + window_size_i;
            next_window_end <= first_time + (window_size_i << 1);
        end else if (update_window) begin
            window_end      <= next_window_end;
            next_window_end <= next_window_end + window_size_i;
        end
    end

    assign rd_en_o         = rd_en_q;
    assign update_window_o = update_window;
    assign meas_active_o   = meas_active;

endmodule

`default_nettype wire
